/* sched_cfg.svh */
`ifndef SCHED_CFG_SVH
`define SCHED_CFG_SVH

// Receive ports and cores
`define SCHED_IF_COUNT   2
`define SCHED_CORE_COUNT 4

// Free slots per core, numbered from 1
`define SCHED_SLOT_COUNT 8

// Wide enough to hold a full count of 8
`define SCHED_SLOT_W     4
`define SCHED_CORE_W     2

`define SCHED_DATA_W     32

// Returned for an unknown host opcode
`define SCHED_BAD_READ   32'hFEFEFEFE

`endif

/* sched_pkg.sv */
`include "sched_cfg.svh"

package sched_pkg;

  // Per-port receive state
  typedef enum logic [1:0] {
    STALL = 2'd0,
    READY = 2'd1,
    BUSY  = 2'd2
  } port_state_e;

  // Descriptor tag stamped on every beat sent to a core
  typedef struct packed {
    logic [`SCHED_CORE_W-1:0] core;
    logic [`SCHED_SLOT_W-1:0] slot;
  } desc_tag_t;

  typedef struct packed {
    logic [`SCHED_DATA_W-1:0] data;
    logic                     last;
  } beat_t;

  // Slot handed back by a core
  typedef struct packed {
    logic                     valid;
    logic [`SCHED_CORE_W-1:0] core;
    logic [`SCHED_SLOT_W-1:0] slot;
  } slot_ret_t;

endpackage

/* host_cmd_pkg.sv */
`include "sched_cfg.svh"

package host_cmd_pkg;

  typedef enum logic [2:0] {
    OP_ENABLE     = 3'd0,
    OP_INIT_SLOTS = 3'd1,
    OP_FLUSH      = 3'd2,
    OP_READ_COUNT = 3'd3,
    OP_READ_PORT  = 3'd4,
    OP_NONE       = 3'd7
  } host_op_e;

  // Single-cycle host strobe, index selects a core or a port
  typedef struct packed {
    logic                     valid;
    logic                     write;
    host_op_e                 op;
    logic [`SCHED_CORE_W-1:0] index;
    logic [31:0]              wr_data;
  } host_cmd_t;

endpackage

/* slot_keeper.sv */
`timescale 1ns/1ps
`include "sched_cfg.svh"

module slot_keeper (
  input  logic                     clk,
  input  logic                     rst_r,
  input  logic                     init,
  input  logic [`SCHED_SLOT_W-1:0] init_count,
  input  logic                     flush,
  input  sched_pkg::slot_ret_t     push,
  input  logic                     pop,
  output logic [`SCHED_SLOT_W-1:0] head_slot,
  output logic [`SCHED_SLOT_W-1:0] count
);

  localparam int DEPTH = `SCHED_SLOT_COUNT;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int SW    = `SCHED_SLOT_W;

  logic [SW-1:0]    mem [DEPTH];
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr;
  logic             do_push;
  logic             do_pop;
  logic [SW-1:0]    fill;

  assign do_pop    = pop && (count != '0);
  assign do_push   = push.valid && (count != SW'(DEPTH));
  assign fill      = (init_count > SW'(DEPTH)) ? SW'(DEPTH) : init_count;
  assign head_slot = mem[rd_ptr];

  // Init lays down slots 1..DEPTH, only the first fill entries count
  always_ff @(posedge clk) begin
    if (init) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= SW'(i + 1);
      end
    end else if (do_push) begin
      mem[wr_ptr] <= push.slot;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else if (flush) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else if (init) begin
      rd_ptr <= '0;
      wr_ptr <= fill[PTR_W-1:0];
      count  <= fill;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + SW'(do_push) - SW'(do_pop);
    end
  end

endmodule

/* core_picker.sv */
`timescale 1ns/1ps
`include "sched_cfg.svh"

module core_picker (
  input  logic [`SCHED_CORE_COUNT-1:0][`SCHED_SLOT_W-1:0] counts,
  input  logic [`SCHED_CORE_COUNT-1:0]                    enabled,
  output logic                                            pick_valid,
  output logic [`SCHED_CORE_W-1:0]                        pick_core
);

  localparam int N  = `SCHED_CORE_COUNT;
  localparam int SW = `SCHED_SLOT_W;
  localparam int CW = `SCHED_CORE_W;

  // Heap-ordered tree, node 1 is the root and leaves sit at N..2N-1
  logic [SW-1:0] node_val [1:2*N-1];
  logic [CW-1:0] node_idx [1:2*N-1];
  logic          node_vld [1:2*N-1];

  always_comb begin
    for (int i = 0; i < N; i++) begin
      node_val[N+i] = counts[i];
      node_idx[N+i] = CW'(i);
      node_vld[N+i] = enabled[i] && (counts[i] != '0);
    end
    // Left child holds lower indices, so right wins only when strictly larger
    for (int n = N - 1; n >= 1; n--) begin
      if (node_vld[2*n+1] && (!node_vld[2*n] || (node_val[2*n+1] > node_val[2*n]))) begin
        node_val[n] = node_val[2*n+1];
        node_idx[n] = node_idx[2*n+1];
        node_vld[n] = 1'b1;
      end else begin
        node_val[n] = node_val[2*n];
        node_idx[n] = node_idx[2*n];
        node_vld[n] = node_vld[2*n];
      end
    end
  end

  assign pick_valid = node_vld[1];
  assign pick_core  = node_idx[1];

endmodule

/* host_regs.sv */
`timescale 1ns/1ps
`include "sched_cfg.svh"

module host_regs (
  input  logic                                            clk,
  input  logic                                            rst_r,
  input  host_cmd_pkg::host_cmd_t                         host_cmd,
  input  logic [`SCHED_CORE_COUNT-1:0][`SCHED_SLOT_W-1:0] counts,
  input  sched_pkg::port_state_e [`SCHED_IF_COUNT-1:0]    port_state,
  input  sched_pkg::desc_tag_t [`SCHED_IF_COUNT-1:0]      port_tag,
  output logic [`SCHED_CORE_COUNT-1:0]                    enabled,
  output logic [`SCHED_CORE_COUNT-1:0]                    init,
  output logic [`SCHED_SLOT_W-1:0]                        init_count,
  output logic [`SCHED_CORE_COUNT-1:0]                    flush,
  output logic [31:0]                                     host_rd_data
);

  localparam int NC = `SCHED_CORE_COUNT;
  localparam int PW = (`SCHED_IF_COUNT > 1) ? $clog2(`SCHED_IF_COUNT) : 1;

  host_cmd_pkg::host_cmd_t cmd_r;
  logic                    wr_r;
  logic [PW-1:0]           port_idx;
  logic [31:0]             rd_next;

  always_ff @(posedge clk) begin
    cmd_r <= host_cmd;
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      wr_r <= 1'b0;
    end else begin
      wr_r <= host_cmd.valid && host_cmd.write;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      enabled <= '0;
    end else if (wr_r && (cmd_r.op == host_cmd_pkg::OP_ENABLE)) begin
      enabled <= cmd_r.wr_data[NC-1:0];
    end
  end

  // One-cycle strobes to the indexed core
  always_comb begin
    init  = '0;
    flush = '0;
    if (wr_r && (cmd_r.op == host_cmd_pkg::OP_INIT_SLOTS)) begin
      init[cmd_r.index] = 1'b1;
    end
    if (wr_r && (cmd_r.op == host_cmd_pkg::OP_FLUSH)) begin
      flush[cmd_r.index] = 1'b1;
    end
  end

  assign init_count = cmd_r.wr_data[`SCHED_SLOT_W-1:0];

  // Read data is taken straight from the strobe so it lands one cycle later
  assign port_idx = host_cmd.index[PW-1:0];

  always_comb begin
    case (host_cmd.op)
      host_cmd_pkg::OP_ENABLE:     rd_next = 32'(enabled);
      host_cmd_pkg::OP_READ_COUNT: rd_next = 32'(counts[host_cmd.index]);
      host_cmd_pkg::OP_READ_PORT:  rd_next = 32'({port_state[port_idx], 2'b00,
                                                  port_tag[port_idx]});
      default:                     rd_next = `SCHED_BAD_READ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      host_rd_data <= '0;
    end else if (host_cmd.valid && !host_cmd.write) begin
      host_rd_data <= rd_next;
    end
  end

endmodule

/* port_ctrl.sv */
`timescale 1ns/1ps
`include "sched_cfg.svh"

module port_ctrl (
  input  logic                                            clk,
  input  logic                                            rst_r,
  input  sched_pkg::beat_t [`SCHED_IF_COUNT-1:0]          rx_beat,
  input  logic [`SCHED_IF_COUNT-1:0]                      rx_valid,
  input  logic [`SCHED_IF_COUNT-1:0]                      core_ready,
  input  logic                                            pick_valid,
  input  logic [`SCHED_CORE_W-1:0]                        pick_core,
  input  logic [`SCHED_CORE_COUNT-1:0][`SCHED_SLOT_W-1:0] head_slots,
  output logic [`SCHED_IF_COUNT-1:0]                      rx_ready,
  output sched_pkg::beat_t [`SCHED_IF_COUNT-1:0]          core_beat,
  output logic [`SCHED_IF_COUNT-1:0]                      core_valid,
  output sched_pkg::desc_tag_t [`SCHED_IF_COUNT-1:0]      core_tag,
  output logic [`SCHED_CORE_COUNT-1:0]                    pop,
  output sched_pkg::port_state_e [`SCHED_IF_COUNT-1:0]    port_state
);

  localparam int NP = `SCHED_IF_COUNT;
  localparam int NC = `SCHED_CORE_COUNT;
  localparam int PW = (NP > 1) ? $clog2(NP) : 1;

  sched_pkg::port_state_e [NP-1:0] state_next;
  logic [NP-1:0]                   stalled;
  logic [NP-1:0]                   accept;
  logic [NP-1:0]                   grant;
  logic [PW-1:0]                   rr_ptr;
  logic [PW-1:0]                   grant_idx;
  logic                            grant_v;

  always_comb begin
    for (int p = 0; p < NP; p++) begin
      stalled[p] = (port_state[p] == sched_pkg::STALL);
    end
  end

  // Beats pass straight through once a port holds a tag
  assign rx_ready   = ~stalled & core_ready;
  assign core_valid = ~stalled & rx_valid;
  assign core_beat  = rx_beat;
  assign accept     = rx_valid & rx_ready;

  // Round robin over stalled ports, starting at rr_ptr
  always_comb begin
    int p;
    grant_v   = 1'b0;
    grant_idx = rr_ptr;
    for (int k = 0; k < NP; k++) begin
      p = (int'(rr_ptr) + k) % NP;
      if (!grant_v && pick_valid && stalled[p]) begin
        grant_v   = 1'b1;
        grant_idx = PW'(p);
      end
    end
    grant = grant_v ? (NP'(1) << grant_idx) : '0;
  end

  // Only the picked core gives up its head slot
  assign pop = grant_v ? (NC'(1) << pick_core) : '0;

  always_comb begin
    for (int p = 0; p < NP; p++) begin
      state_next[p] = port_state[p];
      case (port_state[p])
        sched_pkg::STALL: if (grant[p]) state_next[p] = sched_pkg::READY;
        sched_pkg::READY: if (accept[p]) begin
          state_next[p] = rx_beat[p].last ? sched_pkg::STALL : sched_pkg::BUSY;
        end
        sched_pkg::BUSY:  if (accept[p] && rx_beat[p].last) state_next[p] = sched_pkg::STALL;
        default:          state_next[p] = sched_pkg::STALL;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      for (int p = 0; p < NP; p++) begin
        port_state[p] <= sched_pkg::STALL;
      end
      rr_ptr   <= '0;
      core_tag <= '0;
    end else begin
      port_state <= state_next;
      if (grant_v) begin
        rr_ptr <= (int'(grant_idx) == NP - 1) ? '0 : grant_idx + 1'b1;
        core_tag[grant_idx] <= '{core: pick_core, slot: head_slots[pick_core]};
      end
    end
  end

endmodule

/* rx_scheduler.sv */
`timescale 1ns/1ps
`include "sched_cfg.svh"

module rx_scheduler (
  input  logic                                       clk,
  input  logic                                       rst_r,
  input  sched_pkg::beat_t [`SCHED_IF_COUNT-1:0]     rx_beat,
  input  logic [`SCHED_IF_COUNT-1:0]                 rx_valid,
  output logic [`SCHED_IF_COUNT-1:0]                 rx_ready,
  output sched_pkg::beat_t [`SCHED_IF_COUNT-1:0]     core_beat,
  output logic [`SCHED_IF_COUNT-1:0]                 core_valid,
  input  logic [`SCHED_IF_COUNT-1:0]                 core_ready,
  output sched_pkg::desc_tag_t [`SCHED_IF_COUNT-1:0] core_tag,
  input  sched_pkg::slot_ret_t                       slot_ret,
  input  host_cmd_pkg::host_cmd_t                    host_cmd,
  output logic [31:0]                                host_rd_data
);

  localparam int NC = `SCHED_CORE_COUNT;
  localparam int CW = `SCHED_CORE_W;

  logic [NC-1:0][`SCHED_SLOT_W-1:0]                 counts;
  logic [NC-1:0][`SCHED_SLOT_W-1:0]                 head_slots;
  logic [NC-1:0]                                    enabled;
  logic [NC-1:0]                                    init;
  logic [NC-1:0]                                    flush;
  logic [NC-1:0]                                    pop;
  logic [`SCHED_SLOT_W-1:0]                         init_count;
  logic                                             pick_valid;
  logic [CW-1:0]                                    pick_core;
  sched_pkg::port_state_e [`SCHED_IF_COUNT-1:0]     port_state;

  host_regs u_host_regs (
    .clk          (clk),
    .rst_r        (rst_r),
    .host_cmd     (host_cmd),
    .counts       (counts),
    .port_state   (port_state),
    .port_tag     (core_tag),
    .enabled      (enabled),
    .init         (init),
    .init_count   (init_count),
    .flush        (flush),
    .host_rd_data (host_rd_data)
  );

  core_picker u_core_picker (
    .counts     (counts),
    .enabled    (enabled),
    .pick_valid (pick_valid),
    .pick_core  (pick_core)
  );

  port_ctrl u_port_ctrl (
    .clk        (clk),
    .rst_r      (rst_r),
    .rx_beat    (rx_beat),
    .rx_valid   (rx_valid),
    .core_ready (core_ready),
    .pick_valid (pick_valid),
    .pick_core  (pick_core),
    .head_slots (head_slots),
    .rx_ready   (rx_ready),
    .core_beat  (core_beat),
    .core_valid (core_valid),
    .core_tag   (core_tag),
    .pop        (pop),
    .port_state (port_state)
  );

  for (genvar i = 0; i < NC; i++) begin : g_core
    sched_pkg::slot_ret_t ret_i;

    // Returned slot goes only to the core it belongs to
    assign ret_i = '{valid: slot_ret.valid && (slot_ret.core == CW'(i)),
                     core:  slot_ret.core,
                     slot:  slot_ret.slot};

    slot_keeper u_slot_keeper (
      .clk        (clk),
      .rst_r      (rst_r),
      .init       (init[i]),
      .init_count (init_count),
      .flush      (flush[i]),
      .push       (ret_i),
      .pop        (pop[i]),
      .head_slot  (head_slots[i]),
      .count      (counts[i])
    );
  end

endmodule

/* tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
  parameter int HALF_PERIOD = 10,
  parameter int RST_CYCLES  = 4
) (
  output logic clk,
  output logic rst_r
);

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // Reset drops 1 ns after the last reset edge, like the rest of the stimulus
  initial begin
    rst_r = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    #1;
    rst_r = 1'b0;
  end

endmodule

/* tb_rx_scheduler.sv */
`timescale 1ns/1ps
`include "sched_cfg.svh"

module tb_rx_scheduler;

  localparam int NP              = `SCHED_IF_COUNT;
  localparam int NC              = `SCHED_CORE_COUNT;
  localparam int DEPTH           = `SCHED_SLOT_COUNT;
  localparam int PKTS            = 12;
  localparam int MAX_LEN         = 4;
  localparam int WATCHDOG_CYCLES = 40 * NP * PKTS * MAX_LEN + 500;

  logic                                       clk;
  logic                                       rst_r;
  sched_pkg::beat_t [NP-1:0]                  rx_beat;
  logic [NP-1:0]                              rx_valid;
  logic [NP-1:0]                              rx_ready;
  sched_pkg::beat_t [NP-1:0]                  core_beat;
  logic [NP-1:0]                              core_valid;
  logic [NP-1:0]                              core_ready;
  sched_pkg::desc_tag_t [NP-1:0]              core_tag;
  sched_pkg::slot_ret_t                       slot_ret;
  host_cmd_pkg::host_cmd_t                    host_cmd;
  logic [31:0]                                host_rd_data;

  logic [31:0]                                lcg_state = 32'd3;
  int                                         errors = 0;
  logic [NP-1:0]                              port_done = '0;
  logic                                       returns_on = 1'b0;

  // Reference model of the slot lists, port states and tags
  sched_pkg::port_state_e                     m_state [NP];
  sched_pkg::desc_tag_t                       m_tag [NP];
  logic [7:0]                                 m_seq [NP];
  logic [NC-1:0]                              m_en;
  logic [31:0]                                exp_rd;
  logic [`SCHED_SLOT_W-1:0]                   mq [NC][DEPTH];
  int                                         mhead [NC];
  int                                         msize [NC];
  int                                         m_rr;
  logic                                       pend_wr;
  host_cmd_pkg::host_cmd_t                    pend_cmd;

  tb_clock u_clock (
    .clk   (clk),
    .rst_r (rst_r)
  );

  rx_scheduler dut (
    .clk          (clk),
    .rst_r        (rst_r),
    .rx_beat      (rx_beat),
    .rx_valid     (rx_valid),
    .rx_ready     (rx_ready),
    .core_beat    (core_beat),
    .core_valid   (core_valid),
    .core_ready   (core_ready),
    .core_tag     (core_tag),
    .slot_ret     (slot_ret),
    .host_cmd     (host_cmd),
    .host_rd_data (host_rd_data)
  );

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic logic [31:0] expected_read(input host_cmd_pkg::host_cmd_t c);
    int p;
    p = int'(c.index) % NP;
    case (c.op)
      host_cmd_pkg::OP_ENABLE:     return 32'(m_en);
      host_cmd_pkg::OP_READ_COUNT: return 32'(msize[c.index]);
      host_cmd_pkg::OP_READ_PORT:  return {22'd0, m_state[p], 2'b00, m_tag[p]};
      default:                     return `SCHED_BAD_READ;
    endcase
  endfunction

  task automatic log_mismatch(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
    errors++;
    $display("FAILED %0t %s got %0h expected %0h", $time, name, got, exp);
  endtask

  task automatic finish_run(input bit timed_out);
    $display("Errors: %0d failed checks, %0d timeouts", errors, timed_out ? 1 : 0);
    if (errors == 0 && !timed_out) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  endtask

  task automatic host_issue(input logic write, input host_cmd_pkg::host_op_e op,
                            input logic [1:0] idx, input logic [31:0] data);
    host_cmd = '{valid: 1'b1, write: write, op: op, index: idx, wr_data: data};
    @(posedge clk);
    #1;
    host_cmd.valid = 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  // Low byte of the data carries a per-port sequence number
  task automatic send_port(input int p);
    logic [31:0] r;
    logic [7:0]  seq;
    int          len;
    bit          took;
    seq = '0;
    for (int k = 0; k < PKTS; k++) begin
      r = next_rand();
      len = 1 + int'(r[29:28]);
      for (int b = 0; b < len; b++) begin
        r = next_rand();
        rx_beat[p] = '{data: {r[31:8], seq}, last: (b == len - 1)};
        rx_valid[p] = 1'b1;
        took = 1'b0;
        while (!took) begin
          @(negedge clk);
          took = rx_ready[p];
          @(posedge clk);
          #1;
        end
        seq = seq + 8'd1;
      end
    end
    rx_valid[p] = 1'b0;
    port_done[p] = 1'b1;
  endtask

  task automatic run_host();
    logic [31:0] r;
    idle_cycles(6);
    host_issue(1'b1, host_cmd_pkg::OP_INIT_SLOTS, 2'd0, 32'd3);
    host_issue(1'b1, host_cmd_pkg::OP_INIT_SLOTS, 2'd1, 32'd5);
    host_issue(1'b1, host_cmd_pkg::OP_INIT_SLOTS, 2'd2, 32'd6);
    host_issue(1'b1, host_cmd_pkg::OP_INIT_SLOTS, 2'd3, 32'd2);
    host_issue(1'b0, host_cmd_pkg::OP_READ_COUNT, 2'd2, 32'd0);
    returns_on = 1'b1;
    // Core 2 holds the most slots but stays disabled
    host_issue(1'b1, host_cmd_pkg::OP_ENABLE, 2'd0, 32'hB);
    idle_cycles(1);
    host_issue(1'b0, host_cmd_pkg::OP_ENABLE, 2'd0, 32'd0);
    while (port_done != '1) begin
      r = next_rand();
      case (r[29:28])
        2'd0:    host_issue(1'b0, host_cmd_pkg::OP_READ_COUNT, r[31:30], 32'd0);
        2'd1:    host_issue(1'b0, host_cmd_pkg::OP_READ_PORT, r[31:30], 32'd0);
        2'd2:    host_issue(1'b0, host_cmd_pkg::OP_NONE, r[31:30], 32'd0);
        default: idle_cycles(1);
      endcase
    end
    returns_on = 1'b0;
    idle_cycles(4);
    for (int c = 0; c < NC; c++) begin
      host_issue(1'b0, host_cmd_pkg::OP_READ_COUNT, 2'(c), 32'd0);
    end
    host_issue(1'b1, host_cmd_pkg::OP_FLUSH, 2'd1, 32'd0);
    idle_cycles(1);
    host_issue(1'b0, host_cmd_pkg::OP_READ_COUNT, 2'd1, 32'd0);
    host_issue(1'b0, host_cmd_pkg::OP_READ_PORT, 2'd0, 32'd0);
    host_issue(1'b0, host_cmd_pkg::OP_READ_PORT, 2'd1, 32'd0);
    host_issue(1'b0, host_cmd_pkg::OP_NONE, 2'd3, 32'd0);
    idle_cycles(3);
  endtask

  initial begin
    rx_beat  = '0;
    rx_valid = '0;
    host_cmd = '0;
    @(negedge rst_r);
    fork
      send_port(0);
      send_port(1);
      run_host();
    join
    idle_cycles(2);
    finish_run(1'b0);
  end

  // Random back-pressure and slot returns
  initial begin
    logic [31:0] r;
    core_ready = '1;
    slot_ret   = '0;
    forever begin
      @(posedge clk);
      #1;
      r = next_rand();
      for (int p = 0; p < NP; p++) begin
        core_ready[p] = (r[24 + 2 * p +: 2] != 2'b00);
      end
      slot_ret.valid = returns_on && (r[21:20] == 2'b00);
      slot_ret.core  = r[23:22];
      slot_ret.slot  = 4'(r[30:28]) + 4'd1;
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles with traffic still pending",
             WATCHDOG_CYCLES);
    finish_run(1'b1);
  end

  always @(posedge clk) begin
    int  best;
    int  grant_port;
    int  held;
    int  fill;
    bit  room;
    bit  acc;
    if (rst_r) begin
      for (int c = 0; c < NC; c++) begin
        msize[c] = 0;
        mhead[c] = 0;
      end
      for (int p = 0; p < NP; p++) begin
        m_state[p] <= sched_pkg::STALL;
        m_tag[p]   <= '0;
        m_seq[p]   <= '0;
      end
      m_rr = 0;
      pend_wr = 1'b0;
      m_en <= '0;
      exp_rd <= '0;
    end else begin
      if (host_cmd.valid && !host_cmd.write) begin
        exp_rd <= expected_read(host_cmd);
      end
      // The enabled core with the most free slots wins and the lowest index breaks a tie
      best = -1;
      for (int c = 0; c < NC; c++) begin
        if (m_en[c] && msize[c] != 0 && (best < 0 || msize[c] > msize[best])) begin
          best = c;
        end
      end
      grant_port = -1;
      for (int k = 0; k < NP; k++) begin
        if (grant_port < 0 && best >= 0 && m_state[(m_rr + k) % NP] == sched_pkg::STALL) begin
          grant_port = (m_rr + k) % NP;
        end
      end
      // Init or flush overrides push and pop on that core
      held = -1;
      if (pend_wr && (pend_cmd.op == host_cmd_pkg::OP_INIT_SLOTS ||
                      pend_cmd.op == host_cmd_pkg::OP_FLUSH)) begin
        held = int'(pend_cmd.index);
      end
      room = slot_ret.valid && (msize[slot_ret.core] < DEPTH);
      if (grant_port >= 0) begin
        m_tag[grant_port] <= '{core: 2'(best), slot: mq[best][mhead[best]]};
        m_rr = (grant_port + 1) % NP;
        if (best != held) begin
          mhead[best] = (mhead[best] + 1) % DEPTH;
          msize[best]--;
        end
      end
      if (room && int'(slot_ret.core) != held) begin
        mq[slot_ret.core][(mhead[slot_ret.core] + msize[slot_ret.core]) % DEPTH] = slot_ret.slot;
        msize[slot_ret.core]++;
      end
      for (int p = 0; p < NP; p++) begin
        acc = rx_valid[p] && core_ready[p] && (m_state[p] != sched_pkg::STALL);
        if (p == grant_port) begin
          m_state[p] <= sched_pkg::READY;
        end else if (acc && rx_beat[p].last) begin
          m_state[p] <= sched_pkg::STALL;
        end else if (acc) begin
          m_state[p] <= sched_pkg::BUSY;
        end
        if (acc) begin
          m_seq[p] <= m_seq[p] + 8'd1;
        end
      end
      if (pend_wr) begin
        case (pend_cmd.op)
          host_cmd_pkg::OP_ENABLE: m_en <= pend_cmd.wr_data[NC-1:0];
          host_cmd_pkg::OP_INIT_SLOTS: begin
            fill = int'(pend_cmd.wr_data[`SCHED_SLOT_W-1:0]);
            for (int i = 0; i < DEPTH; i++) begin
              mq[pend_cmd.index][i] = 4'(i + 1);
            end
            mhead[pend_cmd.index] = 0;
            msize[pend_cmd.index] = (fill > DEPTH) ? DEPTH : fill;
          end
          host_cmd_pkg::OP_FLUSH: begin
            mhead[pend_cmd.index] = 0;
            msize[pend_cmd.index] = 0;
          end
          default: ;
        endcase
      end
      pend_wr = host_cmd.valid && host_cmd.write;
      pend_cmd = host_cmd;
    end
  end

  for (genvar p = 0; p < NP; p++) begin : g_port_checks
    assert property (@(posedge clk) disable iff (rst_r)
        rx_ready[p] == (core_ready[p] && m_state[p] != sched_pkg::STALL))
      else log_mismatch($sformatf("rx_ready[%0d]", p), 64'($sampled(rx_ready[p])),
                        64'($sampled(core_ready[p] && m_state[p] != sched_pkg::STALL)));

    assert property (@(posedge clk) disable iff (rst_r)
        core_valid[p] == (rx_valid[p] && m_state[p] != sched_pkg::STALL))
      else log_mismatch($sformatf("core_valid[%0d]", p), 64'($sampled(core_valid[p])),
                        64'($sampled(rx_valid[p] && m_state[p] != sched_pkg::STALL)));

    assert property (@(posedge clk) disable iff (rst_r)
        core_valid[p] |-> core_beat[p] == rx_beat[p])
      else log_mismatch($sformatf("core_beat[%0d]", p), 64'($sampled(core_beat[p])),
                        64'($sampled(rx_beat[p])));

    assert property (@(posedge clk) disable iff (rst_r)
        (rx_valid[p] && rx_ready[p]) |-> core_tag[p] == m_tag[p])
      else log_mismatch($sformatf("core_tag[%0d]", p), 64'($sampled(core_tag[p])),
                        64'($sampled(m_tag[p])));

    assert property (@(posedge clk) disable iff (rst_r)
        (rx_valid[p] && rx_ready[p]) |-> core_beat[p].data[7:0] == m_seq[p])
      else log_mismatch($sformatf("core_beat[%0d] sequence", p),
                        64'($sampled(core_beat[p].data[7:0])), 64'($sampled(m_seq[p])));

    assert property (@(posedge clk) disable iff (rst_r)
        core_valid[p] |-> m_en[core_tag[p].core])
      else begin
        errors++;
        $display("Port %0d sent a beat tagged with disabled core %0d at %0t",
                 p, $sampled(core_tag[p].core), $time);
      end
  end

  assert property (@(posedge clk) disable iff (rst_r) host_rd_data == exp_rd)
    else log_mismatch("host_rd_data", 64'($sampled(host_rd_data)), 64'($sampled(exp_rd)));

endmodule

/* filelist.f */
+incdir+.
sched_pkg.sv
host_cmd_pkg.sv
slot_keeper.sv
core_picker.sv
host_regs.sv
port_ctrl.sv
rx_scheduler.sv
tb_clock.sv
tb_rx_scheduler.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_rx_scheduler
RTL_TOP    := rx_scheduler
FILELIST   := filelist.f
OBJ_DIR    := obj_dir
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall
PASS_MSG   := Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
